//--- all.f
+incdir+.
cpu_pkg.sv
cpu_fetch.sv
cpu_regfile.sv
cpu_decode.sv
cpu_execute.sv
cpu_memwb.sv
cpu.sv
tb_cpu.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
FLIST     ?= all.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(MDIR)
	@out="$$(./$(MDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(MDIR)

//--- tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module tb_cpu;

    import cpu_pkg::*;

    localparam int N_BODY  = 200;
    localparam int MARKER  = N_BODY + 7; // self-loop after the epilogue
    localparam int TIMEOUT = 5000;

    logic        clk;
    logic        i_rst_n;
    logic        i_stall;
    logic [31:0] o_pc;
    logic [31:0] i_inst;
    logic        o_dm_w;
    logic [31:0] o_dm_addr;
    logic [31:0] o_dm_wdata;
    logic [31:0] i_dm_rdata;
    logic [31:0] pc_off;

    inst_t       imem [256];
    logic [31:0] dmem [64];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    integer      seed;
    int          n_seen;
    int          n_mismatch;
    int          n_fail;

    cpu i_cpu (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .o_pc       (o_pc),
        .i_inst     (i_inst),
        .o_dm_w     (o_dm_w),
        .o_dm_addr  (o_dm_addr),
        .o_dm_wdata (o_dm_wdata),
        .i_dm_rdata (i_dm_rdata)
    );

    assign pc_off = o_pc - `CPU_RESET_PC;
    assign i_inst = (pc_off[31:10] == '0) ? imem[pc_off[9:2]] : '0; // nop outside the program
    assign i_dm_rdata = dmem[o_dm_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rnd(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return 32'hc0de_0000 ^ (32'(idx) * 32'h0001_0204);
    endfunction

    function automatic logic [31:0] sext(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic inst_t mk_r(input logic [5:0] funct, input int rs, input int rt,
                                   input int rd);
        inst_t w;
        w.r = '{opcode: `OP_RTYPE, rs: 5'(rs), rt: 5'(rt), rd: 5'(rd), shamt: 5'd0,
                funct: funct};
        return w;
    endfunction

    function automatic inst_t mk_i(input logic [5:0] op, input int rs, input int rt,
                                   input logic [15:0] imm);
        inst_t w;
        w.i = '{opcode: op, rs: 5'(rs), rt: 5'(rt), imm: imm};
        return w;
    endfunction

    function automatic logic [5:0] pick_funct(input int k);
        case (k)
            0:       return `FN_ADDU;
            1:       return `FN_SUBU;
            2:       return `FN_AND;
            3:       return `FN_OR;
            default: return `FN_SLT;
        endcase
    endfunction

    task automatic gen_program();
        int k;
        int kind;
        int span;
        for (k = 0; k < N_BODY; k++) begin
            kind = rnd(10);
            span = (N_BODY - k < 4) ? N_BODY - k : 4; // forward and never past the epilogue
            case (kind)
                0, 1, 2: imem[k] = mk_r(pick_funct(rnd(5)), rnd(8), rnd(8), rnd(8));
                3, 4, 9: imem[k] = mk_i(`OP_ADDIU, rnd(8), rnd(8), 16'(rnd(65536)));
                5:       imem[k] = mk_i(`OP_LW, 0, rnd(8), 16'(rnd(64) * 4));
                6:       imem[k] = mk_i(`OP_SW, 0, rnd(8), 16'(rnd(64) * 4));
                7:       imem[k] = mk_i(`OP_BEQ, rnd(8), rnd(8), 16'(rnd(span)));
                default: imem[k] = mk_i(`OP_BNE, rnd(8), rnd(8), 16'(rnd(span)));
            endcase
        end
        for (k = 1; k < 8; k++) begin
            imem[N_BODY + k - 1] = mk_i(`OP_SW, 0, k, 16'(k * 4));
        end
        imem[MARKER] = mk_i(`OP_BEQ, 0, 0, 16'hffff); // branch to itself
    endtask

    // sequential ISS recording every store in program order
    task automatic run_model();
        logic [31:0] rf [32];
        logic [31:0] mem [64];
        inst_t       w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        int          pc;
        int          i;
        for (i = 0; i < 32; i++) begin
            rf[i] = 32'd0;
        end
        for (i = 0; i < 64; i++) begin
            mem[i] = fill_word(i);
        end
        pc = 0;
        while (pc != MARKER) begin
            w = imem[pc];
            pc++;
            a = rf[w.i.rs];
            b = rf[w.i.rt];
            ea = a + sext(w.i.imm);
            case (w.i.opcode)
                `OP_RTYPE: begin
                    case (w.r.funct)
                        `FN_ADDU: rf[w.r.rd] = a + b;
                        `FN_SUBU: rf[w.r.rd] = a - b;
                        `FN_AND:  rf[w.r.rd] = a & b;
                        `FN_OR:   rf[w.r.rd] = a | b;
                        `FN_SLT:  rf[w.r.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:  ;
                    endcase
                end
                `OP_ADDIU: rf[w.i.rt] = ea;
                `OP_LW:    rf[w.i.rt] = mem[ea[7:2]];
                `OP_SW: begin
                    mem[ea[7:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                `OP_BEQ: if (a == b) pc += int'(w.i.imm);
                `OP_BNE: if (a != b) pc += int'(w.i.imm);
                default: ;
            endcase
            rf[0] = 32'd0;
        end
    endtask

    task automatic check_store(input int idx, input logic [31:0] addr,
                               input logic [31:0] data);
        if (addr !== exp_addr[idx]) begin
            n_mismatch++;
            $display("mismatch o_dm_addr store %0d: got %h expected %h",
                     idx, addr, exp_addr[idx]);
        end
        if (data !== exp_data[idx]) begin
            n_mismatch++;
            $display("mismatch o_dm_wdata store %0d: got %h expected %h",
                     idx, data, exp_data[idx]);
        end
    endtask

    task automatic wait_marker();
        int   cyc;
        logic found;
        cyc = 0;
        found = 1'b0;
        while (!found && cyc < TIMEOUT) begin
            @(negedge clk);
            found = (o_pc == `CPU_RESET_PC + 32'(MARKER * 4));
            cyc++;
        end
        if (!found) begin
            n_fail++;
            $display("timeout: the end-of-program loop was never fetched");
        end
    endtask

    task automatic wait_stores();
        int cyc;
        cyc = 0;
        while (n_seen < exp_addr.size() && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (n_seen < exp_addr.size()) begin
            n_fail++;
            $display("timeout: only %0d of %0d stores arrived", n_seen, exp_addr.size());
        end
    endtask

    // data memory filled while reset is low
    always @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (o_dm_w) begin
            dmem[o_dm_addr[7:2]] <= o_dm_wdata;
        end
    end

    // store port is stable mid-cycle
    always @(negedge clk) begin
        if (i_rst_n && o_dm_w) begin
            if (i_stall) begin
                n_fail++;
                $display("store issued while i_stall was high at %0t", $time);
            end
            if (n_seen < exp_addr.size()) begin
                check_store(n_seen, o_dm_addr, o_dm_wdata);
            end else begin
                n_fail++;
                $display("extra store beyond the expected %0d, address %h",
                         exp_addr.size(), o_dm_addr);
            end
            n_seen++;
        end
    end

    initial begin
        i_stall = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            i_stall = (rnd(100) < 20); // about one cycle in five
        end
    end

    initial begin
        seed = 32'hb907_3f75;
        i_rst_n = 1'b0;
        n_seen = 0;
        n_mismatch = 0;
        n_fail = 0;
        for (int k = 0; k < 256; k++) begin
            imem[k] = '0;
        end
        gen_program();
        run_model();
        repeat (3) @(posedge clk);
        #1;
        i_rst_n = 1'b1;
        wait_marker();
        wait_stores();
        repeat (8) @(posedge clk); // room for a stray late store
        if (n_seen != exp_addr.size()) begin
            n_fail++;
            $display("store count wrong: saw %0d stores, expected %0d",
                     n_seen, exp_addr.size());
        end
        $display("errors: %0d mismatches, %0d other failures, %0d of %0d stores checked",
                 n_mismatch, n_fail, n_seen, exp_addr.size());
        if (n_mismatch + n_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_stall,
    output logic [31:0] o_pc,
    input  logic [31:0] i_inst,
    output logic        o_dm_w,
    output logic [31:0] o_dm_addr,
    output logic [31:0] o_dm_wdata,
    input  logic [31:0] i_dm_rdata
);

    import cpu_pkg::*;

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    rf_wr_t      mem_wr;
    rf_wr_t      wb_wr;
    logic        hold;
    logic        redirect;
    logic [31:0] redirect_pc;

    cpu_fetch u_fetch (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_hold        (hold),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_inst        (i_inst),
        .o_pc          (o_pc),
        .o_if_id       (if_id)
    );

    cpu_decode u_decode (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_stall  (i_stall),
        .i_if_id  (if_id),
        .i_wb_wr  (wb_wr),
        .i_flush  (redirect), // kills the instruction behind the branch
        .o_hold   (hold),
        .o_id_ex  (id_ex)
    );

    cpu_execute u_execute (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_stall       (i_stall),
        .i_id_ex       (id_ex),
        .i_mem_wr      (mem_wr),
        .i_wb_wr       (wb_wr),
        .o_redirect    (redirect),
        .o_redirect_pc (redirect_pc),
        .o_ex_mem      (ex_mem)
    );

    cpu_memwb u_memwb (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_stall    (i_stall),
        .i_ex_mem   (ex_mem),
        .i_dm_rdata (i_dm_rdata),
        .o_dm_w     (o_dm_w),
        .o_dm_addr  (o_dm_addr),
        .o_dm_wdata (o_dm_wdata),
        .o_mem_wr   (mem_wr),
        .o_wb_wr    (wb_wr)
    );

endmodule

//--- cpu_memwb.sv
`timescale 1ns/1ps

module cpu_memwb (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_stall,
    input  cpu_pkg::ex_mem_t i_ex_mem,
    input  logic [31:0]      i_dm_rdata,
    output logic             o_dm_w,
    output logic [31:0]      o_dm_addr,
    output logic [31:0]      o_dm_wdata,
    output cpu_pkg::rf_wr_t  o_mem_wr,
    output cpu_pkg::rf_wr_t  o_wb_wr
);

    logic [31:0] mem_result;

    assign o_dm_w = i_ex_mem.mem_write & ~i_stall; // no store while frozen
    assign o_dm_addr = i_ex_mem.alu_out;
    assign o_dm_wdata = i_ex_mem.st_data;

    // load data or ALU result
    assign mem_result = i_ex_mem.mem_read ? i_dm_rdata : i_ex_mem.alu_out;

    assign o_mem_wr = '{wena:  i_ex_mem.rf_wena,
                        waddr: i_ex_mem.rf_waddr,
                        wdata: mem_result};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wb_wr <= '0;
        end else if (!i_stall) begin
            o_wb_wr <= o_mem_wr;
        end
    end

endmodule

//--- cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_stall,
    input  cpu_pkg::id_ex_t  i_id_ex,
    input  cpu_pkg::rf_wr_t  i_mem_wr,
    input  cpu_pkg::rf_wr_t  i_wb_wr,
    output logic             o_redirect,
    output logic [31:0]      o_redirect_pc,
    output cpu_pkg::ex_mem_t o_ex_mem
);

    import cpu_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] alu_out;

    // memory-stage result is younger, so it wins
    function automatic logic [31:0] fwd(input logic [4:0] rnum,
                                        input logic [31:0] rval,
                                        input rf_wr_t mem_wr,
                                        input rf_wr_t wb_wr);
        if (rnum == 5'd0) begin
            return rval;
        end
        if (mem_wr.wena && mem_wr.waddr == rnum) begin
            return mem_wr.wdata;
        end
        if (wb_wr.wena && wb_wr.waddr == rnum) begin
            return wb_wr.wdata;
        end
        return rval;
    endfunction

    assign op_a = fwd(i_id_ex.rs, i_id_ex.rs_val, i_mem_wr, i_wb_wr);
    assign op_b = fwd(i_id_ex.rt, i_id_ex.rt_val, i_mem_wr, i_wb_wr);
    assign alu_b = i_id_ex.use_imm ? i_id_ex.imm : op_b;

    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD: alu_out = op_a + alu_b;
            ALU_SUB: alu_out = op_a - alu_b;
            ALU_AND: alu_out = op_a & alu_b;
            ALU_OR:  alu_out = op_a | alu_b;
            ALU_SLT: alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            default: alu_out = '0;
        endcase
    end

    // predicted not-taken, so a taken branch redirects
    assign o_redirect = i_id_ex.valid && i_id_ex.branch
                        && ((op_a == op_b) ^ i_id_ex.branch_ne);
    assign o_redirect_pc = i_id_ex.br_target;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem <= '0;
        end else if (!i_stall) begin
            o_ex_mem <= '{mem_read:  i_id_ex.valid & i_id_ex.mem_read,
                          mem_write: i_id_ex.valid & i_id_ex.mem_write,
                          rf_wena:   i_id_ex.valid & i_id_ex.rf_wena,
                          rf_waddr:  i_id_ex.rf_waddr,
                          alu_out:   alu_out,
                          st_data:   op_b};
        end
    end

endmodule

//--- cpu_decode.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_decode (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_stall,
    input  cpu_pkg::if_id_t i_if_id,
    input  cpu_pkg::rf_wr_t i_wb_wr,
    input  logic            i_flush,
    output logic            o_hold,
    output cpu_pkg::id_ex_t o_id_ex
);

    import cpu_pkg::*;

    inst_t       inst;
    rf_wr_t      rf_wr;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm_sext;
    id_ex_t      dec;
    logic        hold;

    assign inst = i_if_id.inst;
    assign imm_sext = {{16{inst.i.imm[15]}}, inst.i.imm};

    // write-back register holds during a stall, so no write then
    assign rf_wr = '{wena: i_wb_wr.wena & ~i_stall,
                     waddr: i_wb_wr.waddr,
                     wdata: i_wb_wr.wdata};

    cpu_regfile u_regfile (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_wr     (rf_wr),
        .i_raddr1 (inst.i.rs),
        .i_raddr2 (inst.i.rt),
        .o_rdata1 (rs_val),
        .o_rdata2 (rt_val)
    );

    always_comb begin
        dec = '0;
        dec.valid = i_if_id.valid;
        dec.alu_op = ALU_ADD;
        dec.rs = inst.i.rs;
        dec.rt = inst.i.rt;
        dec.rs_val = rs_val;
        dec.rt_val = rt_val;
        dec.imm = imm_sext;
        dec.br_target = i_if_id.pc4 + {imm_sext[29:0], 2'b00};
        case (inst.i.opcode)
            `OP_RTYPE: begin
                dec.rf_waddr = inst.r.rd;
                dec.rf_wena = 1'b1;
                case (inst.r.funct)
                    `FN_ADDU: dec.alu_op = ALU_ADD;
                    `FN_SUBU: dec.alu_op = ALU_SUB;
                    `FN_AND:  dec.alu_op = ALU_AND;
                    `FN_OR:   dec.alu_op = ALU_OR;
                    `FN_SLT:  dec.alu_op = ALU_SLT;
                    default:  dec.rf_wena = 1'b0; // unknown funct, no-op
                endcase
            end
            `OP_ADDIU: begin
                dec.use_imm = 1'b1;
                dec.rf_wena = 1'b1;
                dec.rf_waddr = inst.i.rt;
            end
            `OP_LW: begin
                dec.use_imm = 1'b1;
                dec.mem_read = 1'b1;
                dec.rf_wena = 1'b1;
                dec.rf_waddr = inst.i.rt;
            end
            `OP_SW: begin
                dec.use_imm = 1'b1;
                dec.mem_write = 1'b1;
            end
            `OP_BEQ: dec.branch = 1'b1;
            `OP_BNE: begin
                dec.branch = 1'b1;
                dec.branch_ne = 1'b1;
            end
            default: ; // anything else runs as a no-op
        endcase
    end

    // load in execute feeding the instruction here
    assign hold = i_if_id.valid && o_id_ex.valid && o_id_ex.mem_read
                  && (o_id_ex.rf_waddr != 5'd0)
                  && (o_id_ex.rf_waddr == inst.i.rs || o_id_ex.rf_waddr == inst.i.rt);
    assign o_hold = hold;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else if (!i_stall) begin
            if (i_flush || hold) begin
                o_id_ex <= '0; // bubble
            end else begin
                o_id_ex <= dec;
            end
        end
    end

endmodule

//--- cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_regfile (
    input  logic             clk,
    input  logic             i_rst_n,
    input  cpu_pkg::rf_wr_t  i_wr,
    input  logic [4:0]       i_raddr1,
    input  logic [4:0]       i_raddr2,
    output logic [31:0]      o_rdata1,
    output logic [31:0]      o_rdata2
);

    logic [31:0] regs [`CPU_NUM_REGS];
    logic        wr_live;

    assign wr_live = i_wr.wena && (i_wr.waddr != 5'd0); // $0 never written

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_wr.waddr] <= i_wr.wdata;
        end
    end

    // write-through so decode sees this cycle's write-back
    assign o_rdata1 = (wr_live && i_wr.waddr == i_raddr1) ? i_wr.wdata
                                                          : regs[i_raddr1];
    assign o_rdata2 = (wr_live && i_wr.waddr == i_raddr2) ? i_wr.wdata
                                                          : regs[i_raddr2];

endmodule

//--- cpu_fetch.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_fetch (
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_stall,
    input  logic            i_hold,
    input  logic            i_redirect,
    input  logic [31:0]     i_redirect_pc,
    input  logic [31:0]     i_inst,
    output logic [31:0]     o_pc,
    output cpu_pkg::if_id_t o_if_id
);

    logic [31:0] pc_q;
    logic [31:0] pc_plus4;

    assign pc_plus4 = pc_q + 32'd4;
    assign o_pc = pc_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= `CPU_RESET_PC;
        end else if (!i_stall) begin
            if (i_redirect) begin
                pc_q <= i_redirect_pc; // taken branch from execute
            end else if (!i_hold) begin
                pc_q <= pc_plus4;
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_if_id <= '0;
        end else if (!i_stall) begin
            if (i_redirect) begin
                o_if_id.valid <= 1'b0; // squash wrong-path fetch
            end else if (!i_hold) begin
                o_if_id <= '{valid: 1'b1, inst: i_inst, pc4: pc_plus4};
            end
        end
    end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } inst_r_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } inst_i_t;

    // one instruction word, seen as R-type or I-type
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        inst_t       inst;
        logic [31:0] pc4;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        alu_op_e     alu_op;
        logic        use_imm;
        logic        mem_read;
        logic        mem_write;
        logic        branch;
        logic        branch_ne;
        logic        rf_wena;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rf_waddr;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm;
        logic [31:0] br_target;
    } id_ex_t;

    typedef struct packed {
        logic        mem_read;
        logic        mem_write;
        logic        rf_wena;
        logic [4:0]  rf_waddr;
        logic [31:0] alu_out;
        logic [31:0] st_data;
    } ex_mem_t;

    typedef struct packed {
        logic        wena;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_wr_t;

endpackage

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_RESET_PC  32'h0040_0000
`define CPU_NUM_REGS  32

// primary opcodes
`define OP_RTYPE      6'h00
`define OP_ADDIU      6'h09
`define OP_LW         6'h23
`define OP_SW         6'h2b
`define OP_BEQ        6'h04
`define OP_BNE        6'h05

// funct field of R-type
`define FN_ADDU       6'h21
`define FN_SUBU       6'h23
`define FN_AND        6'h24
`define FN_OR         6'h25
`define FN_SLT        6'h2a

`endif
